// File: vlog.f
rtl/frame_pkg.sv
rtl/bank_writer.sv
rtl/frame_bank.sv
rtl/bank_read_mux.sv
rtl/vga_timing.sv
rtl/mandel_display_top.sv
tests/vga_frame_monitor.sv
tests/tb_mandel_display.sv

// File: Bender.yml
package:
  name: mandel_display

sources:
  - files:
      - rtl/frame_pkg.sv
      - rtl/bank_writer.sv
      - rtl/frame_bank.sv
      - rtl/bank_read_mux.sv
      - rtl/vga_timing.sv
      - rtl/mandel_display_top.sv
  - target: test
    files:
      - tests/vga_frame_monitor.sv
      - tests/tb_mandel_display.sv

// File: tests/tb_mandel_display.sv
module tb_mandel_display;
	timeunit 1ns;
	timeprecision 100ps;
	import frame_pkg::*;

	////////////////////////////////////////
	// setup
	////////////////////////////////////////

	// 8x6 picture, short porches
	localparam vga_timing_t TIMING = '{
		H_ACTIVE: 10'd7, H_FRONT: 10'd1, H_PULSE: 10'd1, H_BACK: 10'd2,
		V_ACTIVE: 10'd5, V_FRONT: 10'd1, V_PULSE: 10'd1, V_BACK: 10'd2
	};
	localparam int N_BANKS = 4;
	localparam iter_t MAX_ITER = 32'd100;
	localparam int PIXELS = 48;
	localparam int DEPTH = PIXELS / N_BANKS;
	localparam int FRAMES = 2;
	localparam int PERIOD = 4;
	localparam int LINE_CLKS = int'(TIMING.H_ACTIVE) + int'(TIMING.H_FRONT)
		+ int'(TIMING.H_PULSE) + int'(TIMING.H_BACK) + 4;
	localparam int FRAME_CLKS = LINE_CLKS * (int'(TIMING.V_ACTIVE) + int'(TIMING.V_FRONT)
		+ int'(TIMING.V_PULSE) + int'(TIMING.V_BACK) + 4);
	localparam int WATCHDOG_NS = FRAMES * (PIXELS + 3 * FRAME_CLKS) * PERIOD * 2;

	// counts per frame in raster order, around every band edge
	localparam iter_t COUNTS [FRAMES * PIXELS] = '{
		0, 1, 2, 3, 4, 5, 6, 7, 11, 12, 13, 24,
		25, 26, 49, 50, 51, 99, 100, 101, 500, 0, 1, 2,
		3, 5, 6, 11, 12, 24, 25, 99, 100, 2, 12, 6,
		3, 1, 0, 25, 24, 5, 11, 101, 13, 4, 26, 7,
		101, 100, 99, 26, 25, 24, 13, 12, 11, 7, 6, 5,
		4, 3, 2, 1, 0, 0, 1, 3, 6, 12, 25, 100,
		7, 13, 26, 101, 2, 4, 11, 24, 50, 1000, 0, 5,
		12, 6, 25, 3, 2, 99, 11, 24, 100, 1, 0, 13
	};
	// rgb332 expected for each count above
	localparam pixel_t COLOURS [FRAMES * PIXELS] = '{
		8'h52, 8'h6A, 8'h6A, 8'h25, 8'h25, 8'h25, 8'h65, 8'h65, 8'h65, 8'hA9, 8'hA9, 8'hA9,
		8'h64, 8'h64, 8'h64, 8'h64, 8'h64, 8'h64, 8'h00, 8'h00, 8'h00, 8'h52, 8'h6A, 8'h6A,
		8'h25, 8'h25, 8'h65, 8'h65, 8'hA9, 8'hA9, 8'h64, 8'h64, 8'h00, 8'h6A, 8'hA9, 8'h65,
		8'h25, 8'h6A, 8'h52, 8'h64, 8'hA9, 8'h25, 8'h65, 8'h00, 8'hA9, 8'h25, 8'h64, 8'h65,
		8'h00, 8'h00, 8'h64, 8'h64, 8'h64, 8'hA9, 8'hA9, 8'hA9, 8'h65, 8'h65, 8'h65, 8'h25,
		8'h25, 8'h25, 8'h6A, 8'h6A, 8'h52, 8'h52, 8'h6A, 8'h25, 8'h65, 8'hA9, 8'h64, 8'h00,
		8'h65, 8'hA9, 8'h64, 8'h00, 8'h6A, 8'h25, 8'h65, 8'hA9, 8'h64, 8'h00, 8'h52, 8'h25,
		8'hA9, 8'h65, 8'h64, 8'h25, 8'h6A, 8'h64, 8'h65, 8'hA9, 8'h00, 8'h6A, 8'h52, 8'hA9
	};

	logic M10k_pll = 1'b0;
	logic reset;
	logic restart;
	logic [N_BANKS-1:0] iter_valid;
	logic [N_BANKS-1:0] iter_ready;
	iter_t iter_count [N_BANKS];
	logic frame_ready;
	logic vga_hs;
	logic vga_vs;
	logic vga_blank_n;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;

	int errors = 0;
	int seed = 90691;
	// monitor queue sizes when the display starts
	int pix_base;
	int hs_base;
	int vs_base;

	always #(PERIOD / 2) M10k_pll = ~M10k_pll;

	mandel_display_top #(
		.TIMING(TIMING),
		.N_BANKS(N_BANKS),
		.MAX_ITER(MAX_ITER)
	) dut_i (
		.M10k_pll(M10k_pll),
		.reset(reset),
		.restart(restart),
		.iter_valid(iter_valid),
		.iter_ready(iter_ready),
		.iter_count(iter_count),
		.frame_ready(frame_ready),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_blank_n(vga_blank_n),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

	vga_frame_monitor mon_i (
		.M10k_pll(M10k_pll),
		.hs(vga_hs),
		.vs(vga_vs),
		.blank_n(vga_blank_n),
		.red(vga_r),
		.green(vga_g),
		.blue(vga_b)
	);

	task automatic log_error(input string msg);
		errors++;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	////////////////////////////////////////
	// stream driver
	////////////////////////////////////////

	// all banks in parallel, random idle gaps
	task automatic feed_frame(input int f);
		int idx [N_BANKS];
		int left;
		logic [N_BANKS-1:0] ready_q;
		logic [N_BANKS-1:0] taken;
		idx = '{default: 0};
		left = PIXELS;
		ready_q = iter_ready;
		while (left > 0) begin
			@(posedge M10k_pll);
			// accepted at this edge
			taken = iter_valid & ready_q;
			for (int b = 0; b < N_BANKS; b++) begin
				if (taken[b]) begin
					idx[b]++;
					left--;
				end
			end
			#1;
			ready_q = iter_ready;
			if (frame_ready) log_error("frame_ready high before every bank was filled");
			if ((vga_r | vga_g | vga_b) != 8'd0) log_error("colour not black while filling");
			for (int b = 0; b < N_BANKS; b++) begin
				if (ready_q[b] != (idx[b] < DEPTH)) begin
					log_error($sformatf("bank %0d ready %0b after %0d items", b, ready_q[b], idx[b]));
				end
				// an offered item stays until taken
				if (!iter_valid[b] || taken[b]) begin
					iter_valid[b] = (idx[b] < DEPTH) && (($random(seed) & 3) != 0);
					if (idx[b] < DEPTH) iter_count[b] = COUNTS[f * PIXELS + b * DEPTH + idx[b]];
				end
			end
		end
		// last write lands one edge later
		@(posedge M10k_pll);
		#1;
		if (!frame_ready) log_error("frame_ready not high one cycle after the last write");
		pix_base = mon_i.pixels.size();
		hs_base = mon_i.hs_runs.size();
		vs_base = mon_i.vs_runs.size();
		// full banks must refuse more items
		iter_valid = '1;
		repeat (3) begin
			@(posedge M10k_pll);
			#1;
			if (iter_ready != '0) log_error($sformatf("full banks ready %b", iter_ready));
		end
		iter_valid = '0;
	endtask

	////////////////////////////////////////
	// frame checks
	////////////////////////////////////////

	task automatic check_frame(input int f);
		int n_pix;
		pixel_t got;
		// end of the first vs pulse closes the frame
		while (mon_i.vs_runs.size() <= vs_base) begin
			@(posedge M10k_pll);
		end
		n_pix = mon_i.pixels.size() - pix_base;
		if (n_pix != PIXELS) log_error($sformatf("frame %0d has %0d visible pixels", f, n_pix));
		for (int i = 0; i < PIXELS && i < n_pix; i++) begin
			got = mon_i.pixels[pix_base + i];
			if (got != COLOURS[f * PIXELS + i]) begin
				log_error($sformatf("frame %0d pixel %0d: got %02h, expected %02h",
					f, i, got, COLOURS[f * PIXELS + i]));
			end
		end
		if (mon_i.vs_runs[vs_base] != (int'(TIMING.V_PULSE) + 1) * LINE_CLKS) begin
			log_error($sformatf("vs low for %0d clocks", mon_i.vs_runs[vs_base]));
		end
		if (mon_i.hs_runs.size() <= hs_base) log_error("no hs pulse during the frame");
		for (int i = hs_base; i < mon_i.hs_runs.size(); i++) begin
			if (mon_i.hs_runs[i] != int'(TIMING.H_PULSE) + 1) begin
				log_error($sformatf("hs low for %0d clocks", mon_i.hs_runs[i]));
			end
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		reset = 1'b1;
		restart = 1'b0;
		iter_valid = '0;
		iter_count = '{default: '0};
		repeat (5) @(posedge M10k_pll);
		#1;
		reset = 1'b0;
		if (iter_ready != '1) log_error("iter_ready not all high after reset");
		if (frame_ready) log_error("frame_ready high after reset");
		feed_frame(0);
		check_frame(0);
		// one cycle restart pulse
		@(posedge M10k_pll);
		#1;
		restart = 1'b1;
		@(posedge M10k_pll);
		#1;
		restart = 1'b0;
		if (frame_ready) log_error("frame_ready still high after restart");
		if (iter_ready != '1) log_error("iter_ready not all high after restart");
		feed_frame(1);
		check_frame(1);
		if (mon_i.low_bits != 0) log_error("padding bits of a colour output set");
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("errors: %0d", errors);
		$display("Something failed");
		$finish;
	end

endmodule

// File: tests/vga_frame_monitor.sv
module vga_frame_monitor (
	input logic M10k_pll,
	input logic hs,
	input logic vs,
	input logic blank_n,
	input logic [7:0] red,
	input logic [7:0] green,
	input logic [7:0] blue
);
	timeunit 1ns;
	timeprecision 100ps;
	import frame_pkg::*;

	// visible pixels in raster order, all frames back to back
	pixel_t pixels [$];
	// sync low run lengths in clocks, pushed as each run ends
	int hs_runs [$];
	int vs_runs [$];
	// visible samples with a padding bit set
	int low_bits = 0;
	int hs_len = 0;
	int vs_len = 0;

	// falling edge, well clear of the output registers
	always @(negedge M10k_pll) begin
		if (blank_n) begin
			pixels.push_back({red[7:5], green[7:5], blue[7:6]});
			if (red[4:0] != 5'd0 || green[4:0] != 5'd0 || blue[5:0] != 6'd0) begin
				low_bits++;
			end
		end
		// hs pulse
		if (!hs) begin
			hs_len++;
		end else if (hs_len > 0) begin
			hs_runs.push_back(hs_len);
			hs_len = 0;
		end
		// vs pulse, also in clocks
		if (!vs) begin
			vs_len++;
		end else if (vs_len > 0) begin
			vs_runs.push_back(vs_len);
			vs_len = 0;
		end
	end

endmodule

// File: rtl/mandel_display_top.sv
module mandel_display_top #(
	parameter frame_pkg::vga_timing_t TIMING = frame_pkg::VGA_640X480,
	parameter int N_BANKS = 10,
	parameter frame_pkg::iter_t MAX_ITER = 32'd100
) (
	input  logic M10k_pll,
	input  logic reset,
	input  logic restart,
	input  logic [N_BANKS-1:0] iter_valid,
	output logic [N_BANKS-1:0] iter_ready,
	input  frame_pkg::iter_t iter_count [N_BANKS],
	output logic frame_ready,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_blank_n,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);
	import frame_pkg::*;

	// banks split the frame evenly
	localparam int ACTIVE_PIXELS = (int'(TIMING.H_ACTIVE) + 1) * (int'(TIMING.V_ACTIVE) + 1);
	localparam int BANK_DEPTH = ACTIVE_PIXELS / N_BANKS;
	localparam int ADDR_W = $clog2(BANK_DEPTH);

	// write side, one port per bank
	logic wr_en [N_BANKS];
	logic [ADDR_W-1:0] wr_addr [N_BANKS];
	pixel_t wr_pixel [N_BANKS];
	logic [N_BANKS-1:0] bank_full;

	// read side, shared address
	logic [ADDR_W-1:0] rd_addr;
	pixel_t bank_pixels [N_BANKS];
	pixel_t mux_pixel;
	coord_t next_x;
	coord_t next_y;

	////////////////////////////////////////
	// writers and banks
	////////////////////////////////////////

	for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
		// bank b holds pixels b*BANK_DEPTH onward
		bank_writer #(
			.BANK_DEPTH(BANK_DEPTH),
			.MAX_ITER(MAX_ITER)
		) writer_i (
			.M10k_pll(M10k_pll),
			.reset(reset),
			.restart(restart),
			.iter_valid(iter_valid[b]),
			.iter_count(iter_count[b]),
			.iter_ready(iter_ready[b]),
			.wr_en(wr_en[b]),
			.wr_addr(wr_addr[b]),
			.wr_pixel(wr_pixel[b]),
			.full(bank_full[b])
		);

		frame_bank #(
			.BANK_DEPTH(BANK_DEPTH)
		) bank_i (
			.M10k_pll(M10k_pll),
			.wr_en(wr_en[b]),
			.wr_addr(wr_addr[b]),
			.wr_pixel(wr_pixel[b]),
			.rd_addr(rd_addr),
			.rd_pixel(bank_pixels[b])
		);
	end

	// display runs only on a complete frame
	// restart empties the banks, display drops next edge
	assign frame_ready = &bank_full;

	////////////////////////////////////////
	// read path and display
	////////////////////////////////////////

	bank_read_mux #(
		.TIMING(TIMING),
		.N_BANKS(N_BANKS),
		.BANK_DEPTH(BANK_DEPTH)
	) read_mux_i (
		.M10k_pll(M10k_pll),
		.next_x(next_x),
		.next_y(next_y),
		.rd_addr(rd_addr),
		.bank_pixels(bank_pixels),
		.pixel(mux_pixel)
	);

	vga_timing #(
		.TIMING(TIMING)
	) vga_i (
		.M10k_pll(M10k_pll),
		.reset(reset),
		.run(frame_ready),
		.pixel(mux_pixel),
		.next_x(next_x),
		.next_y(next_y),
		.hs(vga_hs),
		.vs(vga_vs),
		.blank_n(vga_blank_n),
		.red(vga_r),
		.green(vga_g),
		.blue(vga_b)
	);

endmodule

// File: rtl/vga_timing.sv
module vga_timing #(
	parameter frame_pkg::vga_timing_t TIMING = frame_pkg::VGA_640X480
) (
	input  logic M10k_pll,
	input  logic reset,
	input  logic run,
	input  frame_pkg::pixel_t pixel,
	output frame_pkg::coord_t next_x,
	output frame_pkg::coord_t next_y,
	output logic hs,
	output logic vs,
	output logic blank_n,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);
	import frame_pkg::*;

	typedef enum logic [1:0] {
		PH_ACTIVE,
		PH_FRONT,
		PH_PULSE,
		PH_BACK
	} phase_t;

	phase_t h_phase;
	phase_t v_phase;
	coord_t h_count;
	coord_t v_count;
	// one clock strobe at the end of each line
	logic line_done;
	// first stage, from the current phase
	logic hs_q;
	logic vs_q;
	logic active_q;
	// idle until the banks are full
	logic hold;

	assign hold = reset || !run;

	// active, front, pulse, back, then around again
	function automatic phase_t phase_after(input phase_t p);
		case (p)
			PH_ACTIVE: return PH_FRONT;
			PH_FRONT:  return PH_PULSE;
			PH_PULSE:  return PH_BACK;
			default:   return PH_ACTIVE;
		endcase
	endfunction

	// last clock index of a horizontal phase
	function automatic coord_t h_last(input phase_t p);
		case (p)
			PH_ACTIVE: return TIMING.H_ACTIVE;
			PH_FRONT:  return TIMING.H_FRONT;
			PH_PULSE:  return TIMING.H_PULSE;
			default:   return TIMING.H_BACK;
		endcase
	endfunction

	// last line index of a vertical phase
	function automatic coord_t v_last(input phase_t p);
		case (p)
			PH_ACTIVE: return TIMING.V_ACTIVE;
			PH_FRONT:  return TIMING.V_FRONT;
			PH_PULSE:  return TIMING.V_PULSE;
			default:   return TIMING.V_BACK;
		endcase
	endfunction

	////////////////////////////////////////
	// horizontal
	////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (hold) begin
			h_phase <= PH_ACTIVE;
			h_count <= '0;
			line_done <= 1'b0;
		end else begin
			// raised one early so it meets the wrap
			line_done <= (h_phase == PH_BACK) && (h_count == h_last(PH_BACK) - 1'b1);
			if (h_count == h_last(h_phase)) begin
				h_count <= '0;
				h_phase <= phase_after(h_phase);
			end else begin
				h_count <= h_count + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// vertical
	////////////////////////////////////////

	// steps once per line
	always_ff @(posedge M10k_pll) begin
		if (hold) begin
			v_phase <= PH_ACTIVE;
			v_count <= '0;
		end else if (line_done) begin
			if (v_count == v_last(v_phase)) begin
				v_count <= '0;
				v_phase <= phase_after(v_phase);
			end else begin
				v_count <= v_count + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// sync and colour out
	////////////////////////////////////////

	// two stages so sync meets the ram read
	always_ff @(posedge M10k_pll) begin
		if (hold) begin
			hs_q <= 1'b1;
			vs_q <= 1'b1;
			active_q <= 1'b0;
			hs <= 1'b1;
			vs <= 1'b1;
			blank_n <= 1'b0;
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			hs_q <= (h_phase != PH_PULSE);
			vs_q <= (v_phase != PH_PULSE);
			active_q <= (h_phase == PH_ACTIVE) && (v_phase == PH_ACTIVE);
			hs <= hs_q;
			vs <= vs_q;
			blank_n <= active_q;
			// widen rgb332, black outside the picture
			red <= active_q ? {pixel[7:5], 5'b0} : 8'd0;
			green <= active_q ? {pixel[4:2], 5'b0} : 8'd0;
			blue <= active_q ? {pixel[1:0], 6'b0} : 8'd0;
		end
	end

	// scan position for the read path, zero in the porches
	assign next_x = (h_phase == PH_ACTIVE) ? h_count : '0;
	assign next_y = (v_phase == PH_ACTIVE) ? v_count : '0;

endmodule

// File: rtl/bank_read_mux.sv
module bank_read_mux #(
	parameter frame_pkg::vga_timing_t TIMING = frame_pkg::VGA_640X480,
	parameter int N_BANKS = 10,
	parameter int BANK_DEPTH = 30720
) (
	input  logic M10k_pll,
	input  frame_pkg::coord_t next_x,
	input  frame_pkg::coord_t next_y,
	output logic [$clog2(BANK_DEPTH)-1:0] rd_addr,
	input  frame_pkg::pixel_t bank_pixels [N_BANKS],
	output frame_pkg::pixel_t pixel
);

	localparam int LINE_W = int'(TIMING.H_ACTIVE) + 1;
	localparam int IDX_W = $clog2(N_BANKS * BANK_DEPTH);
	localparam int ADDR_W = $clog2(BANK_DEPTH);
	localparam int SEL_W = (N_BANKS > 1) ? $clog2(N_BANKS) : 1;

	// linear pixel index of the scan position
	logic [IDX_W-1:0] pixel_idx;
	// first index of the selected bank
	logic [IDX_W-1:0] bank_base;
	logic [SEL_W-1:0] bank_sel;
	// select lined up with the ram output
	logic [SEL_W-1:0] bank_sel_q;

	assign pixel_idx = IDX_W'(next_y * LINE_W + next_x);

	////////////////////////////////////////
	// bank decode
	////////////////////////////////////////

	// highest bank whose base is not above the index
	always_comb begin
		bank_sel = '0;
		bank_base = '0;
		for (int b = 1; b < N_BANKS; b++) begin
			if (pixel_idx >= IDX_W'(b * BANK_DEPTH)) begin
				bank_sel = SEL_W'(b);
				bank_base = IDX_W'(b * BANK_DEPTH);
			end
		end
	end

	// same local address goes to every bank
	assign rd_addr = ADDR_W'(pixel_idx - bank_base);

	// rams answer one edge later
	always_ff @(posedge M10k_pll) begin
		bank_sel_q <= bank_sel;
	end

	assign pixel = bank_pixels[bank_sel_q];

endmodule

// File: rtl/frame_bank.sv
module frame_bank #(
	parameter int BANK_DEPTH = 30720
) (
	input  logic M10k_pll,
	input  logic wr_en,
	input  logic [$clog2(BANK_DEPTH)-1:0] wr_addr,
	input  frame_pkg::pixel_t wr_pixel,
	input  logic [$clog2(BANK_DEPTH)-1:0] rd_addr,
	output frame_pkg::pixel_t rd_pixel
);
	import frame_pkg::*;

	// one slice of the frame, raster order
	pixel_t mem [BANK_DEPTH];

	// single write port from the writer
	// read port registered, old data on a collision
	always_ff @(posedge M10k_pll) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_pixel;
		end
		rd_pixel <= mem[rd_addr];
	end

endmodule

// File: rtl/bank_writer.sv
module bank_writer #(
	parameter int BANK_DEPTH = 30720,
	parameter frame_pkg::iter_t MAX_ITER = 32'd100
) (
	input  logic M10k_pll,
	input  logic reset,
	input  logic restart,
	input  logic iter_valid,
	input  frame_pkg::iter_t iter_count,
	output logic iter_ready,
	output logic wr_en,
	output logic [$clog2(BANK_DEPTH)-1:0] wr_addr,
	output frame_pkg::pixel_t wr_pixel,
	output logic full
);
	import frame_pkg::*;

	localparam int ADDR_W = $clog2(BANK_DEPTH);
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(BANK_DEPTH - 1);

	// next free slot in the bank
	logic [ADDR_W-1:0] addr;
	logic accept;
	// last slot taken, its write still one edge away
	logic last_in_flight;

	assign last_in_flight = wr_en && (wr_addr == LAST_ADDR);

	// stream stalls once the final item is taken
	// full itself waits for the ram write to land
	assign iter_ready = !(full || last_in_flight);
	assign accept = iter_valid && iter_ready;

	////////////////////////////////////////
	// control
	////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset || restart) begin
			addr <= '0;
			full <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			// one write per accepted count
			wr_en <= accept;
			if (accept) begin
				// wrap so a refill starts at zero
				addr <= (addr == LAST_ADDR) ? '0 : addr + 1'b1;
			end
			// set as the last address is written
			if (last_in_flight) begin
				full <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// write data
	////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (accept) begin
			wr_addr <= addr;
			// colour mapped on the way in
			wr_pixel <= color_of_iterations(iter_count, MAX_ITER);
		end
	end

endmodule

// File: rtl/frame_pkg.sv
package frame_pkg;

	////////////////////////////////////////
	// basic types
	////////////////////////////////////////

	// rgb332 colour, red in the top bits
	typedef logic [7:0] pixel_t;

	// escape iteration count from the source
	typedef logic [31:0] iter_t;

	// screen coordinate, also used for porch lengths
	typedef logic [9:0] coord_t;

	////////////////////////////////////////
	// vga timing record
	////////////////////////////////////////

	// each field holds the last index of its phase
	// horizontal in clocks, vertical in lines
	typedef struct packed {
		coord_t H_ACTIVE;
		coord_t H_FRONT;
		coord_t H_PULSE;
		coord_t H_BACK;
		coord_t V_ACTIVE;
		coord_t V_FRONT;
		coord_t V_PULSE;
		coord_t V_BACK;
	} vga_timing_t;

	// standard 640x480 at 60 Hz
	localparam vga_timing_t VGA_640X480 = '{
		H_ACTIVE: 10'd639, H_FRONT: 10'd15, H_PULSE: 10'd95, H_BACK: 10'd47,
		V_ACTIVE: 10'd479, V_FRONT: 10'd9, V_PULSE: 10'd1, V_BACK: 10'd32
	};

	// count to colour, first matching band wins
	// thresholds are the max count shifted right
	function automatic pixel_t color_of_iterations(input iter_t count, input iter_t max_iter);
		// points inside the set stay black
		if (count >= max_iter) return 8'b000_000_00;
		// upper half and quarter share one colour
		if (count >= (max_iter >>> 2)) return 8'b011_001_00;
		if (count >= (max_iter >>> 3)) return 8'b101_010_01;
		if (count >= (max_iter >>> 4)) return 8'b011_001_01;
		if (count >= (max_iter >>> 5)) return 8'b001_001_01;
		if (count >= (max_iter >>> 6)) return 8'b011_010_10;
		// fast escapes
		return 8'b010_100_10;
	endfunction

endpackage
